// ==== design/mem_pkg.sv ====
package mem_pkg;

    // ============================================================
    // Operand source select.
    // ============================================================
    typedef enum logic [1:0] {
        OPSEL_REG = 2'd0,  // Register file value.
        OPSEL_MEM = 2'd1,  // Load data merged in stage 3.
        OPSEL_IMM = 2'd2,  // Immediate field.
        OPSEL_EIP = 2'd3   // Instruction pointer.
    } opsel_e;

    // ============================================================
    // Access size. Word and wide both cover the full data word.
    // ============================================================
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_WIDE = 2'd3
    } opsize_e;

endpackage

// ==== design/mem_issue.sv ====
`timescale 1ns/1ps

module mem_issue #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    input  logic                fwd_stall,
    input  logic                cache_stall,
    input  mem_pkg::opsize_e    opsize_in,
    input  logic [3:0]          size_ovr,
    input  logic [ADDR_W-1:0]   mem_addr,
    input  logic [DATA_W-1:0]   reg1,
    input  logic [DATA_W-1:0]   reg2,
    input  logic [DATA_W-1:0]   imm,
    input  logic [ADDR_W-1:0]   eip_in,
    input  mem_pkg::opsel_e     op1_sel,
    input  mem_pkg::opsel_e     op2_sel,
    output logic                stall,
    output logic                s1_valid,
    output logic                s1_mem_rd,
    output logic [ADDR_W-1:0]   s1_addr,
    output mem_pkg::opsize_e    s1_size,
    output logic [DATA_W-1:0]   s1_op1_pre,
    output logic [DATA_W-1:0]   s1_op2_pre,
    output logic                s1_op1_mem,
    output logic                s1_op2_mem
);

    localparam int OFF_W = $clog2(DATA_W / 8);

    mem_pkg::opsize_e   size_res;
    logic [DATA_W-1:0]  op1_pre;
    logic [DATA_W-1:0]  op2_pre;
    logic               op1_mem;
    logic               op2_mem;
    logic               accept;

    function automatic logic [DATA_W-1:0] presel(
        input mem_pkg::opsel_e    sel,
        input logic [DATA_W-1:0]  reg_val,
        input logic [DATA_W-1:0]  imm_val,
        input logic [DATA_W-1:0]  eip_val
    );
        case (sel)
            mem_pkg::OPSEL_REG: presel = reg_val;
            mem_pkg::OPSEL_IMM: presel = imm_val;
            mem_pkg::OPSEL_EIP: presel = eip_val;
            default:            presel = '0;  // Load data goes here later.
        endcase
    endfunction

    assign stall  = cache_stall | fwd_stall;
    assign accept = valid_in & ~stall;

    // The override bit wins over the decoded size.
    always_comb begin
        if (size_ovr[3])      size_res = mem_pkg::SIZE_WIDE;
        else if (size_ovr[2]) size_res = mem_pkg::SIZE_WORD;
        else if (size_ovr[1]) size_res = mem_pkg::SIZE_HALF;
        else if (size_ovr[0]) size_res = mem_pkg::SIZE_BYTE;
        else                  size_res = opsize_in;
    end

    assign op1_mem = (op1_sel == mem_pkg::OPSEL_MEM);
    assign op2_mem = (op2_sel == mem_pkg::OPSEL_MEM);
    assign op1_pre = presel(op1_sel, reg1, imm, DATA_W'(eip_in));
    assign op2_pre = presel(op2_sel, reg2, imm, DATA_W'(eip_in));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s1_mem_rd <= 1'b0;
        end else if (!stall) begin
            s1_valid  <= valid_in;
            s1_mem_rd <= valid_in & (op1_mem | op2_mem);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_addr    <= mem_addr;
            s1_size    <= size_res;
            s1_op1_pre <= op1_pre;
            s1_op2_pre <= op2_pre;
            s1_op1_mem <= op1_mem;
            s1_op2_mem <= op2_mem;
        end
    end

    a_ovr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> $onehot0(size_ovr))
        else $error("size_ovr has more than one bit set");

    a_addr_align: assert property (@(posedge clk) disable iff (!rst_n)
        accept && (op1_mem || op2_mem) |-> mem_addr[OFF_W-1:0] == '0)
        else $error("unaligned memory address accepted");

endmodule

// ==== design/dcache.sv ====
`timescale 1ns/1ps

module dcache #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 32,
    parameter int LINES  = 16,
    parameter int SIDE_W = 68
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fwd_stall,
    input  logic                s1_valid,
    input  logic                s1_mem_rd,
    input  logic [ADDR_W-1:0]   s1_addr,
    input  logic [SIDE_W-1:0]   s1_side,
    input  logic                wb_valid,
    input  logic [ADDR_W-1:0]   wb_addr,
    input  logic [DATA_W-1:0]   wb_data,
    input  logic                fill_valid,
    input  logic [DATA_W-1:0]   fill_data,
    output logic                cache_stall,
    output logic                fill_req,
    output logic [ADDR_W-1:0]   fill_addr,
    output logic                s2_valid,
    output logic [DATA_W-1:0]   s2_data,
    output logic [SIDE_W-1:0]   s2_side
);

    localparam int OFF_W  = $clog2(DATA_W / 8);
    localparam int IDX_W  = $clog2(LINES);
    localparam int TAG_W  = ADDR_W - IDX_W - OFF_W;
    localparam int WORD_W = ADDR_W - OFF_W;

    // ============================================================
    // Line arrays.
    // ============================================================
    logic [LINES-1:0]   line_valid;
    logic [TAG_W-1:0]   line_tag  [LINES];
    logic [DATA_W-1:0]  line_data [LINES];

    logic [IDX_W-1:0]   s1_idx;
    logic [TAG_W-1:0]   s1_tag;
    logic [IDX_W-1:0]   wb_idx;
    logic [TAG_W-1:0]   wb_tag;
    logic               hit;
    logic               wb_hit;

    // Refill tracking.
    logic               busy;
    logic [WORD_W-1:0]  refill_word;
    logic [IDX_W-1:0]   refill_idx;
    logic [TAG_W-1:0]   refill_tag;
    logic [DATA_W-1:0]  refill_val;

    assign s1_idx = s1_addr[OFF_W +: IDX_W];
    assign s1_tag = s1_addr[ADDR_W-1 -: TAG_W];
    assign wb_idx = wb_addr[OFF_W +: IDX_W];
    assign wb_tag = wb_addr[ADDR_W-1 -: TAG_W];

    assign hit    = line_valid[s1_idx] && (line_tag[s1_idx] == s1_tag);
    assign wb_hit = wb_valid && line_valid[wb_idx] && (line_tag[wb_idx] == wb_tag);

    assign cache_stall = s1_valid & s1_mem_rd & ~hit;
    assign fill_req    = cache_stall & ~busy;  // One request per miss.
    assign fill_addr   = s1_addr;

    assign refill_idx = refill_word[IDX_W-1:0];
    assign refill_tag = refill_word[WORD_W-1 -: TAG_W];

    // A write landing on the refill word in the same cycle wins.
    assign refill_val = (wb_valid && wb_addr[ADDR_W-1:OFF_W] == refill_word) ?
                        wb_data : fill_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            line_valid <= '0;
        end else begin
            if (fill_req) begin
                busy <= 1'b1;
            end else if (fill_valid) begin
                busy <= 1'b0;
            end
            if (fill_valid) begin
                line_valid[refill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_req) begin
            refill_word <= s1_addr[ADDR_W-1:OFF_W];
        end
        if (wb_hit) begin
            line_data[wb_idx] <= wb_data;  // Write-through update.
        end
        if (fill_valid) begin
            line_tag[refill_idx]  <= refill_tag;
            line_data[refill_idx] <= refill_val;
        end
    end

    // ============================================================
    // Stage 2 register.
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else if (!fwd_stall) begin
            s2_valid <= s1_valid & ~cache_stall;  // Bubble on a miss.
        end
    end

    always_ff @(posedge clk) begin
        if (!fwd_stall && !cache_stall) begin
            s2_data <= line_data[s1_idx];
            s2_side <= s1_side;
        end
    end

    a_fill_expected: assert property (@(posedge clk) disable iff (!rst_n)
        fill_valid |-> busy)
        else $error("fill_valid without an outstanding refill");

endmodule

// ==== design/backing_mem.sv ====
`timescale 1ns/1ps

module backing_mem #(
    parameter int DATA_W    = 32,
    parameter int ADDR_W    = 32,
    parameter int MEM_WORDS = 256,
    parameter int FILL_LAT  = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_valid,
    input  logic [ADDR_W-1:0]   wb_addr,
    input  logic [DATA_W-1:0]   wb_data,
    input  logic                fill_req,
    input  logic [ADDR_W-1:0]   fill_addr,
    output logic                fill_valid,
    output logic [DATA_W-1:0]   fill_data
);

    localparam int OFF_W = $clog2(DATA_W / 8);
    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(FILL_LAT + 1);

    logic [DATA_W-1:0]  mem [MEM_WORDS];
    logic [IDX_W-1:0]   fill_idx;
    logic [CNT_W-1:0]   cnt;

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            mem[wb_addr[OFF_W +: IDX_W]] <= wb_data;
        end
        if (fill_req) begin
            fill_idx <= fill_addr[OFF_W +: IDX_W];
        end
    end

    // Countdown to the delivery cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (fill_req) begin
            cnt <= CNT_W'(FILL_LAT);
        end else if (cnt != '0) begin
            cnt <= cnt - CNT_W'(1);
        end
    end

    assign fill_valid = (cnt == CNT_W'(1));
    assign fill_data  = mem[fill_idx];  // Read late, so earlier writes show.

endmodule

// ==== design/operand_merge.sv ====
`timescale 1ns/1ps

module operand_merge #(
    parameter int DATA_W = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fwd_stall,
    input  logic                s2_valid,
    input  logic [DATA_W-1:0]   s2_data,
    input  mem_pkg::opsize_e    s2_size,
    input  logic [DATA_W-1:0]   s2_op1_pre,
    input  logic [DATA_W-1:0]   s2_op2_pre,
    input  logic                s2_op1_mem,
    input  logic                s2_op2_mem,
    output logic                valid_out,
    output logic [DATA_W-1:0]   op1_val,
    output logic [DATA_W-1:0]   op2_val,
    output mem_pkg::opsize_e    opsize_out
);

    logic [DATA_W-1:0]  load_val;
    logic [DATA_W-1:0]  op1_next;
    logic [DATA_W-1:0]  op2_next;
    logic               valid_q;

    // Zero-extend to the access size.
    always_comb begin
        case (s2_size)
            mem_pkg::SIZE_BYTE: load_val = DATA_W'(s2_data[7:0]);
            mem_pkg::SIZE_HALF: load_val = DATA_W'(s2_data[15:0]);
            default:            load_val = s2_data;
        endcase
    end

    assign op1_next = s2_op1_mem ? load_val : s2_op1_pre;
    assign op2_next = s2_op2_mem ? load_val : s2_op2_pre;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!fwd_stall) begin
            valid_q <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!fwd_stall && s2_valid) begin
            op1_val    <= op1_next;
            op2_val    <= op2_next;
            opsize_out <= s2_size;
        end
    end

    assign valid_out = valid_q & ~fwd_stall;  // Held items stay hidden.

endmodule

// ==== design/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
    parameter int DATA_W    = 32,
    parameter int ADDR_W    = 32,
    parameter int LINES     = 16,
    parameter int FILL_LAT  = 4,
    parameter int MEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    input  logic                fwd_stall,
    input  mem_pkg::opsize_e    opsize_in,
    input  logic [3:0]          size_ovr,
    input  logic [ADDR_W-1:0]   mem_addr,
    input  logic [DATA_W-1:0]   reg1,
    input  logic [DATA_W-1:0]   reg2,
    input  logic [DATA_W-1:0]   imm,
    input  logic [ADDR_W-1:0]   eip_in,
    input  mem_pkg::opsel_e     op1_sel,
    input  mem_pkg::opsel_e     op2_sel,
    input  logic                wb_valid,
    input  logic [ADDR_W-1:0]   wb_addr,
    input  logic [DATA_W-1:0]   wb_data,
    output logic                valid_out,
    output logic [DATA_W-1:0]   op1_val,
    output logic [DATA_W-1:0]   op2_val,
    output mem_pkg::opsize_e    opsize_out,
    output logic                stall
);

    // Size, two operands, two memory flags.
    localparam int SIDE_W = 2 * DATA_W + 4;

    logic               cache_stall;
    logic               s1_valid;
    logic               s1_mem_rd;
    logic [ADDR_W-1:0]  s1_addr;
    mem_pkg::opsize_e   s1_size;
    logic [DATA_W-1:0]  s1_op1_pre;
    logic [DATA_W-1:0]  s1_op2_pre;
    logic               s1_op1_mem;
    logic               s1_op2_mem;
    logic [SIDE_W-1:0]  s1_side;
    logic               s2_valid;
    logic [DATA_W-1:0]  s2_data;
    logic [SIDE_W-1:0]  s2_side;
    mem_pkg::opsize_e   s2_size;
    logic               fill_req;
    logic [ADDR_W-1:0]  fill_addr;
    logic               fill_valid;
    logic [DATA_W-1:0]  fill_data;

    assign s1_side = {s1_size, s1_op1_pre, s1_op2_pre, s1_op1_mem, s1_op2_mem};
    assign s2_size = mem_pkg::opsize_e'(s2_side[SIDE_W-1 -: 2]);

    mem_issue #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) mem_issue_inst (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .fwd_stall(fwd_stall),
        .cache_stall(cache_stall), .opsize_in(opsize_in), .size_ovr(size_ovr),
        .mem_addr(mem_addr), .reg1(reg1), .reg2(reg2), .imm(imm), .eip_in(eip_in),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .stall(stall), .s1_valid(s1_valid),
        .s1_mem_rd(s1_mem_rd), .s1_addr(s1_addr), .s1_size(s1_size),
        .s1_op1_pre(s1_op1_pre), .s1_op2_pre(s1_op2_pre),
        .s1_op1_mem(s1_op1_mem), .s1_op2_mem(s1_op2_mem)
    );

    dcache #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .LINES(LINES), .SIDE_W(SIDE_W)) dcache_inst (
        .clk(clk), .rst_n(rst_n), .fwd_stall(fwd_stall), .s1_valid(s1_valid),
        .s1_mem_rd(s1_mem_rd), .s1_addr(s1_addr), .s1_side(s1_side),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
        .fill_valid(fill_valid), .fill_data(fill_data), .cache_stall(cache_stall),
        .fill_req(fill_req), .fill_addr(fill_addr), .s2_valid(s2_valid),
        .s2_data(s2_data), .s2_side(s2_side)
    );

    backing_mem #(
        .DATA_W(DATA_W), .ADDR_W(ADDR_W), .MEM_WORDS(MEM_WORDS), .FILL_LAT(FILL_LAT)
    ) backing_mem_inst (
        .clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .wb_addr(wb_addr),
        .wb_data(wb_data), .fill_req(fill_req), .fill_addr(fill_addr),
        .fill_valid(fill_valid), .fill_data(fill_data)
    );

    operand_merge #(.DATA_W(DATA_W)) operand_merge_inst (
        .clk(clk), .rst_n(rst_n), .fwd_stall(fwd_stall), .s2_valid(s2_valid),
        .s2_data(s2_data), .s2_size(s2_size),
        .s2_op1_pre(s2_side[2*DATA_W+1 -: DATA_W]),
        .s2_op2_pre(s2_side[DATA_W+1 -: DATA_W]),
        .s2_op1_mem(s2_side[1]), .s2_op2_mem(s2_side[0]),
        .valid_out(valid_out), .op1_val(op1_val), .op2_val(op2_val),
        .opsize_out(opsize_out)
    );

endmodule

// ==== sim/mem_stage_tb.sv ====
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int LINES      = 16;
    localparam int FILL_LAT   = 4;
    localparam int MEM_WORDS  = 256;
    localparam int IDX_W      = $clog2(LINES);
    localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
    localparam int N_WRITES   = 24;
    localparam int N_INSTR    = 40 + 2 * N_WRITES + 60 + 60 + 2 * 8;
    localparam int MAX_CYCLES = 3 * N_INSTR * (FILL_LAT + 2);  // Misses plus stall gaps.

    logic               clk;
    logic               rst_n;
    logic               valid_in;
    logic               fwd_stall;
    mem_pkg::opsize_e   opsize_in;
    logic [3:0]         size_ovr;
    logic [31:0]        mem_addr;
    logic [31:0]        reg1;
    logic [31:0]        reg2;
    logic [31:0]        imm;
    logic [31:0]        eip_in;
    mem_pkg::opsel_e    op1_sel;
    mem_pkg::opsel_e    op2_sel;
    logic               wb_valid;
    logic [31:0]        wb_addr;
    logic [31:0]        wb_data;
    logic               valid_out;
    logic [31:0]        op1_val;
    logic [31:0]        op2_val;
    mem_pkg::opsize_e   opsize_out;
    logic               stall;

    // ============================================================
    // Reference model state.
    // ============================================================
    logic [31:0]        shadow [MEM_WORDS];  // Every wb write.
    logic [31:0]        ref_tag [LINES];
    bit                 ref_vld [LINES];
    logic [31:0]        wr_addr [$];
    logic [31:0]        exp_op1 [$];
    logic [31:0]        exp_op2 [$];
    mem_pkg::opsize_e   exp_size [$];
    logic [31:0]        e1;
    logic [31:0]        e2;
    mem_pkg::opsize_e   es;
    string              test_name;
    bit                 first_sent;
    int                 fs_pct;
    int                 cycles;
    int                 miss_count;
    int                 hit_count;
    int                 miss_cycles_exp;
    int                 stall_cycles;

    mem_stage #(.LINES(LINES), .FILL_LAT(FILL_LAT), .MEM_WORDS(MEM_WORDS)) mem_stage_inst (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .fwd_stall(fwd_stall),
        .opsize_in(opsize_in), .size_ovr(size_ovr), .mem_addr(mem_addr),
        .reg1(reg1), .reg2(reg2), .imm(imm), .eip_in(eip_in),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .wb_valid(wb_valid),
        .wb_addr(wb_addr), .wb_data(wb_data), .valid_out(valid_out),
        .op1_val(op1_val), .op2_val(op2_val), .opsize_out(opsize_out), .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        abort_run($sformatf("error %s %s: expected %h, actual %h", test_name, what, exp, act));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles", MAX_CYCLES));
        end
    end

    function automatic mem_pkg::opsize_e resolve_size(input logic [3:0] ovr,
                                                      input mem_pkg::opsize_e dec);
        mem_pkg::opsize_e res;
        res = dec;
        for (int b = 0; b < 4; b++) begin
            if (ovr[b]) res = mem_pkg::opsize_e'(2'(b));  // Override wins.
        end
        return res;
    endfunction

    function automatic logic [31:0] size_mask(input logic [31:0] data,
                                              input mem_pkg::opsize_e size);
        case (size)
            mem_pkg::SIZE_BYTE: return data & 32'h0000_00ff;
            mem_pkg::SIZE_HALF: return data & 32'h0000_ffff;
            default:            return data;
        endcase
    endfunction

    function automatic logic [31:0] operand_value(input mem_pkg::opsel_e sel,
            input logic [31:0] regv, input logic [31:0] immv,
            input logic [31:0] eipv, input logic [31:0] loadv);
        case (sel)
            mem_pkg::OPSEL_REG: return regv;
            mem_pkg::OPSEL_IMM: return immv;
            mem_pkg::OPSEL_EIP: return eipv;
            default:            return loadv;
        endcase
    endfunction

    function automatic mem_pkg::opsel_e pick_sel(input bit use_mem);
        if (use_mem) return mem_pkg::opsel_e'(2'($urandom_range(3)));
        case ($urandom_range(2))
            0:       return mem_pkg::OPSEL_REG;
            1:       return mem_pkg::OPSEL_IMM;
            default: return mem_pkg::OPSEL_EIP;
        endcase
    endfunction

    function automatic logic [31:0] pick_addr();
        return wr_addr[$urandom_range(wr_addr.size() - 1)];
    endfunction

    // Direct-mapped lookup without allocation on write.
    function automatic void note_read(input logic [31:0] addr);
        int idx;
        logic [31:0] tag;
        idx = int'(addr[2 +: IDX_W]);
        tag = addr >> (2 + IDX_W);
        if (ref_vld[idx] && ref_tag[idx] == tag) begin
            hit_count++;
        end else begin
            miss_count++;
            ref_vld[idx] = 1'b1;
            ref_tag[idx] = tag;
            if (fs_pct == 0) miss_cycles_exp += FILL_LAT + 1;
        end
    endfunction

    // ============================================================
    // Driving takes one falling edge per call.
    // ============================================================
    task automatic tick();
        @(negedge clk);
        fwd_stall = (fs_pct != 0) && ($urandom_range(99) < fs_pct);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            tick();
            valid_in = 1'b0;
        end
    endtask

    task automatic drain();
        tick();
        valid_in = 1'b0;
        while (exp_size.size() != 0) tick();
    endtask

    task automatic issue(input mem_pkg::opsize_e size, input logic [3:0] ovr,
            input logic [31:0] addr, input logic [31:0] r1, input logic [31:0] r2,
            input logic [31:0] im, input logic [31:0] ip,
            input mem_pkg::opsel_e sel1, input mem_pkg::opsel_e sel2);
        mem_pkg::opsize_e res;
        logic [31:0] load;
        tick();
        first_sent = 1'b1;
        valid_in   = 1'b1;
        opsize_in  = size;
        size_ovr   = ovr;
        mem_addr   = addr;
        reg1       = r1;
        reg2       = r2;
        imm        = im;
        eip_in     = ip;
        op1_sel    = sel1;
        op2_sel    = sel2;
        #1;
        while (stall) begin  // Hold until taken.
            tick();
            #1;
        end
        res  = resolve_size(ovr, size);
        load = size_mask(shadow[addr[2 +: MEM_IDX_W]], res);
        if (sel1 == mem_pkg::OPSEL_MEM || sel2 == mem_pkg::OPSEL_MEM) note_read(addr);
        exp_op1.push_back(operand_value(sel1, r1, im, ip, load));
        exp_op2.push_back(operand_value(sel2, r2, im, ip, load));
        exp_size.push_back(res);
    endtask

    task automatic send_random(input bit use_mem, input logic [31:0] addr);
        mem_pkg::opsel_e s1;
        mem_pkg::opsel_e s2;
        logic [3:0] ovr;
        s1 = pick_sel(use_mem);
        s2 = pick_sel(use_mem);
        if (use_mem && s1 != mem_pkg::OPSEL_MEM && s2 != mem_pkg::OPSEL_MEM) begin
            if ($urandom_range(1) == 1) s1 = mem_pkg::OPSEL_MEM;
            else s2 = mem_pkg::OPSEL_MEM;
        end
        ovr = ($urandom_range(1) == 1) ? 4'(4'b0001 << $urandom_range(3)) : 4'b0000;
        issue(mem_pkg::opsize_e'(2'($urandom_range(3))), ovr, addr,
              $urandom(), $urandom(), $urandom(), $urandom(), s1, s2);
        if ($urandom_range(3) == 0) idle(1);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        tick();
        wb_valid = 1'b1;
        wb_addr  = addr;
        wb_data  = data;
        shadow[addr[2 +: MEM_IDX_W]] = data;
        tick();
        wb_valid = 1'b0;
    endtask

    // ============================================================
    // Output checks sampled between edges.
    // ============================================================
    always begin
        @(negedge clk);
        #2;
        if (!rst_n || !first_sent) begin
            assert (valid_out === 1'b0 && stall === 1'b0)
                else abort_run("valid_out or stall was high before the first instruction");
        end
        if (fwd_stall) begin
            assert (valid_out === 1'b0 && stall === 1'b1)
                else abort_run("fwd_stall did not hide valid_out and raise stall");
        end
        if (stall && !fwd_stall && fs_pct == 0) stall_cycles++;
        if (valid_out === 1'b1) begin
            assert (exp_size.size() != 0)
                else abort_run("valid_out was high with no item outstanding");
            if (exp_size.size() != 0) begin
                e1 = exp_op1.pop_front();
                e2 = exp_op2.pop_front();
                es = exp_size.pop_front();
                assert (op1_val === e1) else report_mismatch("op1_val", e1, op1_val);
                assert (op2_val === e2) else report_mismatch("op2_val", e2, op2_val);
                assert (opsize_out === es)
                    else report_mismatch("opsize_out", 32'(es), 32'(opsize_out));
            end
        end
    end

    initial begin
        logic [31:0] a;
        void'($urandom(32'haab4));
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        fwd_stall = 1'b0;
        opsize_in = mem_pkg::SIZE_WORD;
        size_ovr  = 4'b0000;
        mem_addr  = '0;
        reg1      = '0;
        reg2      = '0;
        imm       = '0;
        eip_in    = '0;
        op1_sel   = mem_pkg::OPSEL_REG;
        op2_sel   = mem_pkg::OPSEL_REG;
        wb_valid  = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        test_name = "reset_state";
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        idle(5);

        test_name = "reg_operands";
        repeat (40) send_random(1'b0, '0);
        drain();

        for (int i = 0; i < N_WRITES; i++) begin
            a = 32'((i * 7) % MEM_WORDS) << 2;  // Wraps the line index, so lines conflict.
            write_word(a, $urandom());
            wr_addr.push_back(a);
        end

        test_name = "read_miss_hit";
        foreach (wr_addr[i]) begin
            send_random(1'b1, wr_addr[i]);
            send_random(1'b1, wr_addr[i]);
        end
        drain();

        test_name = "miss_hold";
        repeat (60) send_random(1'($urandom_range(1)), pick_addr());
        drain();

        test_name = "fwd_stall";
        fs_pct = 30;
        repeat (60) send_random(1'($urandom_range(1)), pick_addr());
        drain();
        fs_pct = 0;

        test_name = "write_through";
        repeat (8) begin
            a = pick_addr();
            send_random(1'b1, a);
            drain();
            write_word(a, $urandom());
            send_random(1'b1, a);
            drain();
        end

        test_name = "miss_timing";
        assert (stall_cycles == miss_cycles_exp)
            else report_mismatch("miss stall cycles", miss_cycles_exp, stall_cycles);
        assert (miss_count > 0 && hit_count > 0)
            else abort_run("the reads did not cover both a miss and a hit");
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== list.f ====
design/mem_pkg.sv
design/mem_issue.sv
design/dcache.sv
design/backing_mem.sv
design/operand_merge.sv
design/mem_stage.sv
sim/mem_stage_tb.sv
